// File: tb.f
hw/ifetch_pkg.sv
hw/ifu_minidec.sv
hw/ifu_next_pc.sv
hw/ifu_fetch_ctrl.sv
hw/ifu_ir_stage.sv
hw/ifu_ifetch.sv
test/tb_clock_gen.sv
test/ifu_ifetch_checker.sv
test/ifu_ifetch_tb.sv

// File: test/ifu_ifetch_tb.sv
// Fetch unit testbench
`timescale 1ns/1ps

module ifu_ifetch_tb
  import ifetch_pkg::*;
;

  localparam pc_t         PC_RTVEC     = 32'h8000_0000;
  localparam int          N_REQ        = 400;
  localparam int          MAX_DELAY    = 4;
  localparam int          DRAIN_CYC    = 30;
  // Fetches times worst delay, with room for halts and stalls
  localparam int          WATCH_CYCLES = N_REQ * MAX_DELAY * 8 + 500;
  localparam logic [31:0] SEED         = 32'h1baa_93cb;

  logic   clk;
  logic   rst_n;
  pc_t    pc_rtvec;
  logic   req_valid;
  logic   req_ready;
  pc_t    req_pc;
  logic   req_seq;
  logic   rsp_valid;
  logic   rsp_ready;
  logic   rsp_err;
  instr_t rsp_instr;
  logic   o_valid;
  logic   o_ready;
  instr_t o_ir;
  pc_t    o_pc;
  logic   o_buserr;
  logic   o_prdt_taken;
  rfidx_t o_rs1idx;
  rfidx_t o_rs2idx;
  logic   flush_req;
  pc_t    flush_op1;
  pc_t    flush_op2;
  logic   halt_req;
  logic   halt_ack;

  // Generator and reference model state
  logic [31:0] rng;
  pc_t         exp_pc;
  logic        exp_seq;
  logic        flush_pend;
  pc_t         out_pc;
  logic        mem_busy;
  int          mem_cnt;
  int          n_req;
  logic        started;
  logic        draining;
  logic        cur_rv32;
  logic        cur_taken;
  pc_t         cur_off;
  rfidx_t      cur_rs1;
  rfidx_t      cur_rs2;
  logic        cur_rs1_chk;
  logic        cur_rs2_chk;
  // Words accepted into the output register, oldest first
  instr_t      q_ir[$];
  pc_t         q_pc[$];
  logic        q_err[$];
  logic        q_prdt[$];
  logic        q_rv32[$];
  rfidx_t      q_rs1[$];
  rfidx_t      q_rs2[$];
  logic        q_rs1_chk[$];
  logic        q_rs2_chk[$];

  tb_clock_gen u_clk (.clk(clk));

  ifu_ifetch i_ifu_ifetch (.*);

  bind ifu_ifetch ifu_ifetch_checker u_checker (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return {16'h0, rng[31:16]};
  endfunction

  // Full 32-bit value from two generator steps
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[15:0], lo[15:0]};
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      fail_stop("output or request field mismatch");
    end
  endtask

  // Random word of a known class, offset encoded by hand
  task automatic make_word();
    logic [31:0] r;
    logic [31:0] o;
    int          kind;
    int          off_i;
    r     = rand_word();
    kind  = lcg_next() % 6;
    off_i = (int'(lcg_next() % 64) - 32) * 2;
    o     = off_i;
    cur_off = o;
    case (kind)
      0: rsp_instr = {r[31:7], OPC_OP};
      // Quadrant 0 or 2 holds no control transfer
      1: rsp_instr = {r[31:2], r[0], 1'b0};
      2: rsp_instr = {o[20], o[10:1], o[11], o[19:12], r[11:7], OPC_JAL};
      3: rsp_instr = {o[12], o[10:5], r[24:20], r[19:15], r[14:12], o[4:1], o[11],
                      OPC_BRANCH};
      // C.J
      4: rsp_instr = {r[31:16], 3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7],
                      o[3:1], o[5], 2'b01};
      // C.BEQZ or C.BNEZ
      default: rsp_instr = {r[31:16], 2'b11, r[0], o[8], o[4:3], r[9:7], o[7:6],
                            o[2:1], o[5], 2'b01};
    endcase
    cur_rv32  = (kind == 0) || (kind == 2) || (kind == 3);
    cur_taken = (kind == 2) || (kind == 4) ||
                (((kind == 3) || (kind == 5)) && (off_i < 0));
    // Source indexes for the classes that read them, rs1' maps onto x8..x15
    cur_rs1     = (kind == 5) ? {2'b01, r[9:7]} : r[19:15];
    cur_rs2     = r[24:20];
    cur_rs1_chk = (kind == 0) || (kind == 3) || (kind == 5);
    cur_rs2_chk = (kind == 0) || (kind == 3);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    fail_stop("Timeout, the fetch sequence did not complete");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, memory model and scoreboard
  initial begin
    logic req_fire;
    logic rsp_fire;
    logic flush_act;
    int   drain_cnt;
    rng         = SEED;
    rst_n       = 1'b0;
    pc_rtvec    = PC_RTVEC;
    req_ready   = 1'b0;
    rsp_valid   = 1'b0;
    rsp_err     = 1'b0;
    rsp_instr   = '0;
    o_ready     = 1'b0;
    flush_req   = 1'b0;
    flush_op1   = '0;
    flush_op2   = '0;
    halt_req    = 1'b0;
    exp_pc      = PC_RTVEC;
    exp_seq     = 1'b0;
    flush_pend  = 1'b0;
    out_pc      = '0;
    mem_busy    = 1'b0;
    mem_cnt     = 0;
    n_req       = 0;
    started     = 1'b0;
    draining    = 1'b0;
    drain_cnt   = 0;
    cur_rv32    = 1'b0;
    cur_taken   = 1'b0;
    cur_off     = '0;
    cur_rs1     = '0;
    cur_rs2     = '0;
    cur_rs1_chk = 1'b0;
    cur_rs2_chk = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    while (drain_cnt < DRAIN_CYC) begin
      @(posedge clk);
      req_fire  = req_valid & req_ready;
      rsp_fire  = rsp_valid & rsp_ready;
      flush_act = flush_req | flush_pend;
      assert (i_ifu_ifetch.u_checker.fail_cnt == 0)
        else fail_stop("A bound assertion on the fetch unit failed");

      // Output side, compare before this cycle's load
      // Register is full exactly while an accepted word waits
      compare_field("o_valid", o_valid, q_ir.size() > 0);
      if (o_valid && o_ready && !flush_req) begin
        compare_field("o_pc", o_pc, q_pc[0]);
        compare_field("o_ir_lo", o_ir[15:0], q_ir[0][15:0]);
        if (q_rv32[0]) begin
          compare_field("o_ir_hi", o_ir[31:16], q_ir[0][31:16]);
        end
        compare_field("o_buserr", o_buserr, q_err[0]);
        compare_field("o_prdt_taken", o_prdt_taken, q_prdt[0]);
        if (q_rs1_chk[0]) begin
          compare_field("o_rs1idx", o_rs1idx, q_rs1[0]);
        end
        if (q_rs2_chk[0]) begin
          compare_field("o_rs2idx", o_rs2idx, q_rs2[0]);
        end
        void'(q_ir.pop_front());
        void'(q_pc.pop_front());
        void'(q_err.pop_front());
        void'(q_prdt.pop_front());
        void'(q_rv32.pop_front());
        void'(q_rs1.pop_front());
        void'(q_rs2.pop_front());
        void'(q_rs1_chk.pop_front());
        void'(q_rs2_chk.pop_front());
      end
      // Flush drops whatever sits in the register
      if (flush_req) begin
        q_ir.delete();
        q_pc.delete();
        q_err.delete();
        q_prdt.delete();
        q_rv32.delete();
        q_rs1.delete();
        q_rs2.delete();
        q_rs1_chk.delete();
        q_rs2_chk.delete();
      end
      if (rsp_fire && !flush_act) begin
        q_ir.push_back(rsp_instr);
        q_pc.push_back(out_pc);
        q_err.push_back(rsp_err);
        q_prdt.push_back(cur_taken);
        q_rv32.push_back(cur_rv32);
        q_rs1.push_back(cur_rs1);
        q_rs2.push_back(cur_rs2);
        q_rs1_chk.push_back(cur_rs1_chk);
        q_rs2_chk.push_back(cur_rs2_chk);
      end

      // Next request address
      if (flush_req) begin
        exp_pc  = (flush_op1 + flush_op2) & ~pc_t'(1);
        exp_seq = 1'b0;
      end else if (rsp_fire && !flush_pend) begin
        exp_pc  = cur_taken ? out_pc + cur_off : out_pc + (cur_rv32 ? 4 : 2);
        exp_seq = ~cur_taken;
      end
      if (req_fire) begin
        compare_field("req_pc", req_pc, exp_pc);
        compare_field("req_seq", req_seq, exp_seq);
        out_pc  = req_pc;
        n_req   = n_req + 1;
        started = 1'b1;
      end
      if (flush_req && !req_fire) begin
        flush_pend = 1'b1;
      end else if (req_fire) begin
        flush_pend = 1'b0;
      end
      if (n_req >= N_REQ) begin
        draining = 1'b1;
      end
      if (draining) begin
        drain_cnt = drain_cnt + 1;
      end

      // Drive the next cycle
      #1;
      if (rsp_fire) begin
        rsp_valid = 1'b0;
      end
      if (req_fire) begin
        mem_busy = 1'b1;
        mem_cnt  = lcg_next() % MAX_DELAY;
      end
      // Response held until it transfers, word held after that
      if (mem_busy && !rsp_valid) begin
        if (mem_cnt == 0) begin
          make_word();
          rsp_err   = (lcg_next() % 8) == 0;
          rsp_valid = 1'b1;
          mem_busy  = 1'b0;
        end else begin
          mem_cnt = mem_cnt - 1;
        end
      end
      req_ready = (lcg_next() % 4) != 0;
      o_ready   = draining ? 1'b1 : ((lcg_next() % 4) != 0);
      flush_req = started && !draining && ((lcg_next() % 20) == 0);
      if (flush_req) begin
        flush_op1 = rand_word();
        flush_op2 = lcg_next() % 256;
      end
      if (!started || draining) begin
        halt_req = 1'b0;
      end else if (!halt_req) begin
        halt_req = (lcg_next() % 40) == 0;
      end else begin
        halt_req = (lcg_next() % 6) != 0;
      end
    end

    if (i_ifu_ifetch.u_checker.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      fail_stop("A bound assertion on the fetch unit failed");
    end
  end

endmodule

// File: test/ifu_ifetch_checker.sv
// Fetch unit bound assertions
`timescale 1ns/1ps

module ifu_ifetch_checker
  import ifetch_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  input pc_t    pc_rtvec,
  input logic   req_valid,
  input logic   req_ready,
  input pc_t    req_pc,
  input logic   req_seq,
  input logic   rsp_valid,
  input logic   rsp_ready,
  input logic   o_valid,
  input logic   o_ready,
  input instr_t o_ir,
  input pc_t    o_pc,
  input logic   o_buserr,
  input logic   o_prdt_taken,
  input logic   flush_req,
  input pc_t    flush_op1,
  input pc_t    flush_op2,
  input logic   halt_req,
  input logic   halt_ack
);

  // Failure count, watched by the testbench top
  int   fail_cnt = 0;
  logic outs_r;
  pc_t  flush_sum;

  assign flush_sum = flush_op1 + flush_op2;

  // One fetch in flight at most, set on request and clear on response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outs_r <= 1'b0;
    end else if (req_valid & req_ready) begin
      outs_r <= 1'b1;
    end else if (rsp_valid & rsp_ready) begin
      outs_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset and first request
  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !halt_ack && !o_valid)
    else begin $error("halt_ack or o_valid high in reset"); fail_cnt++; end

  a_first_req: assert property (@(posedge clk)
    $rose(rst_n) |=> req_valid && (req_pc == pc_rtvec) && !req_seq)
    else begin $error("first request not at reset vector"); fail_cnt++; end

  ////////////////////////////////////////////////////////////////////////////
  // Flush issued in its own cycle goes to the aligned sum
  a_flush_pc: assert property (@(posedge clk) disable iff (!rst_n)
    flush_req && req_valid && req_ready |->
      (req_pc == {flush_sum[PC_W-1:1], 1'b0}) && !req_seq)
    else begin $error("flush request address wrong"); fail_cnt++; end

  ////////////////////////////////////////////////////////////////////////////
  // Halt
  a_halt_block: assert property (@(posedge clk) disable iff (!rst_n)
    halt_req && halt_ack |-> !(req_valid && req_ready))
    else begin $error("request transferred while halted"); fail_cnt++; end

  a_halt_idle: assert property (@(posedge clk) disable iff (!rst_n)
    halt_ack |-> !outs_r || rsp_valid)
    else begin $error("halt_ack with a fetch in flight"); fail_cnt++; end

  // Acknowledge follows the request once nothing is in flight
  a_halt_rise: assert property (@(posedge clk) disable iff (!rst_n)
    halt_req && (!outs_r || rsp_valid) |=> halt_ack)
    else begin $error("halt_ack did not rise"); fail_cnt++; end

  a_halt_fall: assert property (@(posedge clk) disable iff (!rst_n)
    !halt_req |=> !halt_ack)
    else begin $error("halt_ack did not fall"); fail_cnt++; end

  ////////////////////////////////////////////////////////////////////////////
  // Output held under back-pressure
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !o_ready && !flush_req |=>
      o_valid && $stable(o_ir[15:0]) && $stable(o_pc) &&
      $stable(o_buserr) && $stable(o_prdt_taken))
    else begin $error("output changed while stalled"); fail_cnt++; end

  // Upper half only means something for a 32-bit word
  a_out_hold_hi: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !o_ready && !flush_req && (&o_ir[1:0]) |=> $stable(o_ir[31:16]))
    else begin $error("upper instruction half changed while stalled"); fail_cnt++; end

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // Half of the 40 ns period
  localparam realtime HALF_PERIOD = 20.0;

  initial begin
    clk = 1'b0;
  end

  // Free running, the testbench ends the run
  always begin
    #(HALF_PERIOD);
    clk = ~clk;
  end

endmodule

// File: hw/ifu_ifetch.sv
// Instruction fetch unit
`timescale 1ns/1ps

module ifu_ifetch
  import ifetch_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  pc_t    pc_rtvec,
  // Fetch request
  output logic   req_valid,
  input  logic   req_ready,
  output pc_t    req_pc,
  output logic   req_seq,
  // Fetch response
  input  logic   rsp_valid,
  output logic   rsp_ready,
  input  logic   rsp_err,
  input  instr_t rsp_instr,
  // Toward execution
  output logic   o_valid,
  input  logic   o_ready,
  output instr_t o_ir,
  output pc_t    o_pc,
  output logic   o_buserr,
  output logic   o_prdt_taken,
  output rfidx_t o_rs1idx,
  output rfidx_t o_rs2idx,
  // Flush and halt
  input  logic   flush_req,
  input  pc_t    flush_op1,
  input  pc_t    flush_op2,
  input  logic   halt_req,
  output logic   halt_ack
);

  logic   dec_rv32;
  logic   dec_jal;
  logic   dec_bxx;
  pc_t    dec_imm;
  logic   dec_rs1en;
  logic   dec_rs2en;
  rfidx_t dec_rs1idx;
  rfidx_t dec_rs2idx;
  logic   reset_sel;
  logic   dly_flush;
  logic   pc_ena;
  logic   ir_load;
  logic   ir_ready;
  logic   prdt_taken;
  pc_t    pc;

  ////////////////////////////////////////////////////////////////////////////
  // Decode of the returned word
  ifu_minidec u_minidec (
    .instr   (rsp_instr),
    .rv32    (dec_rv32),
    .is_jal  (dec_jal),
    .is_bxx  (dec_bxx),
    .bjp_imm (dec_imm),
    .rs1en   (dec_rs1en),
    .rs2en   (dec_rs2en),
    .rs1idx  (dec_rs1idx),
    .rs2idx  (dec_rs2idx)
  );

  // Next fetch address
  ifu_next_pc u_next_pc (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_rtvec   (pc_rtvec),
    .rv32       (dec_rv32),
    .is_jal     (dec_jal),
    .is_bxx     (dec_bxx),
    .bjp_imm    (dec_imm),
    .reset_sel  (reset_sel),
    .flush_req  (flush_req),
    .flush_op1  (flush_op1),
    .flush_op2  (flush_op2),
    .dly_flush  (dly_flush),
    .pc_ena     (pc_ena),
    .pc         (pc),
    .pc_nxt     (req_pc),
    .prdt_taken (prdt_taken),
    .req_seq    (req_seq)
  );

  // Handshake sequencing
  ifu_fetch_ctrl u_fetch_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .flush_req (flush_req),
    .halt_req  (halt_req),
    .ir_ready  (ir_ready),
    .req_valid (req_valid),
    .rsp_ready (rsp_ready),
    .reset_sel (reset_sel),
    .dly_flush (dly_flush),
    .pc_ena    (pc_ena),
    .ir_load   (ir_load),
    .halt_ack  (halt_ack)
  );

  // Output register
  ifu_ir_stage u_ir_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .ir_load      (ir_load),
    .instr        (rsp_instr),
    .rsp_err      (rsp_err),
    .rv32         (dec_rv32),
    .rs1en        (dec_rs1en),
    .rs2en        (dec_rs2en),
    .rs1idx       (dec_rs1idx),
    .rs2idx       (dec_rs2idx),
    .prdt_taken   (prdt_taken),
    .pc           (pc),
    .pc_ena       (pc_ena),
    .flush_req    (flush_req),
    .o_ready      (o_ready),
    .ir_ready     (ir_ready),
    .o_valid      (o_valid),
    .o_ir         (o_ir),
    .o_pc         (o_pc),
    .o_buserr     (o_buserr),
    .o_prdt_taken (o_prdt_taken),
    .o_rs1idx     (o_rs1idx),
    .o_rs2idx     (o_rs2idx)
  );

endmodule

// File: hw/ifu_ir_stage.sv
// Instruction register stage
`timescale 1ns/1ps

module ifu_ir_stage
  import ifetch_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ir_load,
  input  instr_t instr,
  input  logic   rsp_err,
  input  logic   rv32,
  input  logic   rs1en,
  input  logic   rs2en,
  input  rfidx_t rs1idx,
  input  rfidx_t rs2idx,
  input  logic   prdt_taken,
  input  pc_t    pc,
  input  logic   pc_ena,
  input  logic   flush_req,
  input  logic   o_ready,
  output logic   ir_ready,
  output logic   o_valid,
  output instr_t o_ir,
  output pc_t    o_pc,
  output logic   o_buserr,
  output logic   o_prdt_taken,
  output rfidx_t o_rs1idx,
  output rfidx_t o_rs2idx
);

  logic   ir_valid_r;
  logic   ir_valid_clr;
  logic   pc_newpend_r;
  logic   pc_load;
  instr_t ir_r;
  pc_t    ir_pc_r;
  logic   err_r;
  logic   prdt_r;
  rfidx_t rs1idx_r;
  rfidx_t rs2idx_r;

  ////////////////////////////////////////////////////////////////////////////
  // Valid bit
  // Emptied by an output transfer or by a flush
  assign ir_valid_clr = (o_valid & o_ready) | (flush_req & ir_valid_r);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir_valid_r <= 1'b0;
    end else if (ir_load) begin
      ir_valid_r <= 1'b1;
    end else if (ir_valid_clr) begin
      ir_valid_r <= 1'b0;
    end
  end

  // Empty or being emptied
  assign ir_ready = ~ir_valid_r | ir_valid_clr;

  // New fetch PC not yet copied into the IR
  assign pc_load = pc_newpend_r & ir_load;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_newpend_r <= 1'b0;
    end else if (pc_ena) begin
      pc_newpend_r <= 1'b1;
    end else if (pc_load) begin
      pc_newpend_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_r[INSTR_W/2-1:0] <= instr[INSTR_W/2-1:0];
      err_r               <= rsp_err;
      prdt_r              <= prdt_taken;
    end
    // Upper half toggles only for 32-bit words
    if (ir_load & rv32) begin
      ir_r[INSTR_W-1:INSTR_W/2] <= instr[INSTR_W-1:INSTR_W/2];
    end
    // Indexes only when the instruction reads them
    if (ir_load & rs1en) begin
      rs1idx_r <= rs1idx;
    end
    if (ir_load & rs2en) begin
      rs2idx_r <= rs2idx;
    end
    if (pc_load) begin
      ir_pc_r <= pc;
    end
  end

  assign o_valid      = ir_valid_r;
  assign o_ir         = ir_r;
  assign o_pc         = ir_pc_r;
  assign o_buserr     = err_r;
  assign o_prdt_taken = prdt_r;
  assign o_rs1idx     = rs1idx_r;
  assign o_rs2idx     = rs2idx_r;

endmodule

// File: hw/ifu_fetch_ctrl.sv
// Fetch sequencing control
`timescale 1ns/1ps

module ifu_fetch_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req_ready,
  input  logic rsp_valid,
  input  logic flush_req,
  input  logic halt_req,
  input  logic ir_ready,
  output logic req_valid,
  output logic rsp_ready,
  output logic reset_sel,
  output logic dly_flush,
  output logic pc_ena,
  output logic ir_load,
  output logic halt_ack
);

  logic reset_flag_r;
  logic reset_req_r;
  logic dly_flush_r;
  logic out_flag_r;
  logic halt_ack_r;
  logic req_hsk;
  logic rsp_hsk;
  logic flush_act;
  logic new_req_ok;
  logic no_outs;

  assign req_hsk   = req_valid & req_ready;
  assign rsp_hsk   = rsp_valid & rsp_ready;
  // Incoming or remembered flush
  assign flush_act = flush_req | dly_flush_r;

  ////////////////////////////////////////////////////////////////////////////
  // Reset flag and reset request
  // Flag is high in reset, request follows one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_flag_r <= 1'b1;
      reset_req_r  <= 1'b0;
    end else begin
      reset_flag_r <= 1'b0;
      if (reset_flag_r & ~reset_req_r) begin
        reset_req_r <= 1'b1;
      end else if (reset_req_r & req_hsk) begin
        reset_req_r <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flush bookkeeping
  // A flush not issued at once is kept until its request transfers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dly_flush_r <= 1'b0;
    end else if (flush_req & ~req_hsk) begin
      dly_flush_r <= 1'b1;
    end else if (dly_flush_r & req_hsk) begin
      dly_flush_r <= 1'b0;
    end
  end

  // Outstanding fetch, set wins over clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_flag_r <= 1'b0;
    end else if (req_hsk) begin
      out_flag_r <= 1'b1;
    end else if (rsp_hsk) begin
      out_flag_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response strobes
  // Next request may go out with the returning response
  assign new_req_ok = ~out_flag_r | rsp_hsk;
  // Halt blocks every request, a flush meanwhile waits as delayed flush
  assign req_valid  = ~halt_req & ~reset_flag_r & new_req_ok;

  // Responses during a flush are always drained
  assign rsp_ready  = flush_act ? 1'b1 : (ir_ready & req_ready);
  assign ir_load    = rsp_hsk & ~flush_act;
  assign pc_ena     = req_hsk | flush_req;

  ////////////////////////////////////////////////////////////////////////////
  // Halt acknowledge
  // A valid response also counts as no outstanding fetch
  assign no_outs = ~out_flag_r | rsp_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halt_ack_r <= 1'b0;
    end else if (halt_req & ~halt_ack_r & no_outs) begin
      halt_ack_r <= 1'b1;
    end else if (halt_ack_r & ~halt_req) begin
      halt_ack_r <= 1'b0;
    end
  end

  assign reset_sel = reset_req_r;
  assign dly_flush = dly_flush_r;
  assign halt_ack  = halt_ack_r;

endmodule

// File: hw/ifu_next_pc.sv
// Fetch PC and next address
`timescale 1ns/1ps

module ifu_next_pc
  import ifetch_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  pc_t  pc_rtvec,
  // Decode of the returned word
  input  logic rv32,
  input  logic is_jal,
  input  logic is_bxx,
  input  pc_t  bjp_imm,
  // Address source selection
  input  logic reset_sel,
  input  logic flush_req,
  input  pc_t  flush_op1,
  input  pc_t  flush_op2,
  input  logic dly_flush,
  input  logic pc_ena,
  output pc_t  pc,
  output pc_t  pc_nxt,
  output logic prdt_taken,
  output logic req_seq
);

  pc_t pc_r;
  pc_t add_op1;
  pc_t add_op2;
  pc_t add_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Static prediction
  // JAL always taken
  // Conditional branch taken only when the offset points backward
  assign prdt_taken = is_jal | (is_bxx & bjp_imm[PC_W-1]);

  ////////////////////////////////////////////////////////////////////////////
  // Operand select for the single adder
  always_comb begin
    if (flush_req) begin
      // Flush target from execution
      add_op1 = flush_op1;
      add_op2 = flush_op2;
    end else if (dly_flush) begin
      // PC already holds the flush target
      add_op1 = pc_r;
      add_op2 = '0;
    end else if (prdt_taken) begin
      add_op1 = pc_r;
      add_op2 = bjp_imm;
    end else if (reset_sel) begin
      add_op1 = pc_rtvec;
      add_op2 = '0;
    end else begin
      // Sequential step by instruction length
      add_op1 = pc_r;
      add_op2 = rv32 ? PC_STEP_RV32 : PC_STEP_RVC;
    end
  end

  assign add_sum = add_op1 + add_op2;

  // Halfword aligned fetch address
  assign pc_nxt = {add_sum[PC_W-1:1], 1'b0};

  // Sequential only in the step case
  assign req_seq = ~flush_req & ~dly_flush & ~prdt_taken & ~reset_sel;

  ////////////////////////////////////////////////////////////////////////////
  // PC register
  // Loads on request transfer or incoming flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_r <= '0;
    end else if (pc_ena) begin
      pc_r <= pc_nxt;
    end
  end

  assign pc = pc_r;

endmodule

// File: hw/ifu_minidec.sv
// Fetch mini decoder
`timescale 1ns/1ps

module ifu_minidec
  import ifetch_pkg::*;
(
  input  instr_t instr,
  output logic   rv32,
  output logic   is_jal,
  output logic   is_bxx,
  output pc_t    bjp_imm,
  output logic   rs1en,
  output logic   rs2en,
  output rfidx_t rs1idx,
  output rfidx_t rs2idx
);

  logic [6:0] opcode;
  logic [1:0] quad;
  logic [2:0] f3;
  logic       c_j;
  logic       c_bxx;
  logic       c_nors1;
  logic       c_cmp;
  logic       rs1en_32;
  logic       rs2en_32;
  logic       rs1en_16;
  logic       rs2en_16;
  pc_t        imm_j;
  pc_t        imm_b;
  pc_t        imm_cj;
  pc_t        imm_cb;

  // Both low bits set marks a 32-bit encoding
  assign rv32   = &instr[1:0];
  assign opcode = instr[6:0];
  assign quad   = instr[1:0];
  assign f3     = instr[15:13];

  ////////////////////////////////////////////////////////////////////////////
  // Branch and jump classification
  assign c_j    = (quad == RVC_Q1) & (f3 == RVC_F3_J);
  assign c_bxx  = (quad == RVC_Q1) & ((f3 == RVC_F3_BEQZ) | (f3 == RVC_F3_BNEZ));
  assign is_jal = rv32 ? (opcode == OPC_JAL) : c_j;
  assign is_bxx = rv32 ? (opcode == OPC_BRANCH) : c_bxx;

  // Sign-extended offsets, bit 0 always zero
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  // C.J scrambled offset[11|4|9:8|10|6|7|3:1|5]
  assign imm_cj = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7],
                   instr[2], instr[11], instr[5:3], 1'b0};
  // C.BEQZ/C.BNEZ offset[8|4:3] and [7:6|2:1|5]
  assign imm_cb = {{24{instr[12]}}, instr[6:5], instr[2], instr[11:10], instr[4:3], 1'b0};

  assign bjp_imm = rv32 ? (is_jal ? imm_j : imm_b) : (c_j ? imm_cj : imm_cb);

  ////////////////////////////////////////////////////////////////////////////
  // Source register usage
  // No rs1 for JAL, LUI, AUIPC
  assign rs1en_32 = ~((opcode == OPC_JAL) | (opcode == OPC_LUI) | (opcode == OPC_AUIPC));
  assign rs2en_32 = (opcode == OPC_BRANCH) | (opcode == OPC_STORE) |
                    (opcode == OPC_OP) | (opcode == OPC_AMO);

  // C.LI and C.LUI only write rd; rd == x2 in the LUI slot is C.ADDI16SP
  assign c_nors1  = (quad == RVC_Q1) &
                    ((f3 == RVC_F3_LI) | ((f3 == RVC_F3_LUI) & (instr[11:7] != 5'd2)));
  assign rs1en_16 = ~(c_j | c_nors1);
  // Stores, register-register ALU ops, C.MV and C.ADD
  assign rs2en_16 = (((quad == RVC_Q0) | (quad == RVC_Q2)) & (f3 == RVC_F3_SW)) |
                    ((quad == RVC_Q1) & (f3 == RVC_F3_ARITH) & (instr[11:10] == 2'b11)) |
                    ((quad == RVC_Q2) & (f3 == RVC_F3_ARITH) & (|instr[6:2]));

  assign rs1en = rv32 ? rs1en_32 : rs1en_16;
  assign rs2en = rv32 ? rs2en_32 : rs2en_16;

  // Three-bit register fields map onto x8..x15
  assign c_cmp  = (quad == RVC_Q0) | ((quad == RVC_Q1) & instr[15]);
  assign rs1idx = rv32  ? instr[19:15] :
                  c_cmp ? {2'b01, instr[9:7]} : instr[11:7];
  assign rs2idx = rv32  ? instr[24:20] :
                  c_cmp ? {2'b01, instr[4:2]} : instr[6:2];

endmodule

// File: hw/ifetch_pkg.sv
// Instruction fetch shared definitions
package ifetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  localparam int PC_W    = 32;
  localparam int INSTR_W = 32;
  localparam int RFIDX_W = 5;

  typedef logic [PC_W-1:0]    pc_t;
  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [RFIDX_W-1:0] rfidx_t;

  ////////////////////////////////////////////////////////////////////////////
  // RV32 major opcodes, instr[6:0]
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_AMO    = 7'b010_1111;

  ////////////////////////////////////////////////////////////////////////////
  // RVC quadrants, instr[1:0]
  localparam logic [1:0] RVC_Q0 = 2'b00;
  localparam logic [1:0] RVC_Q1 = 2'b01;
  localparam logic [1:0] RVC_Q2 = 2'b10;

  // RVC funct3, instr[15:13]
  localparam logic [2:0] RVC_F3_LI    = 3'b010;
  localparam logic [2:0] RVC_F3_LUI   = 3'b011;
  localparam logic [2:0] RVC_F3_ARITH = 3'b100;
  localparam logic [2:0] RVC_F3_J     = 3'b101;
  localparam logic [2:0] RVC_F3_BEQZ  = 3'b110;
  localparam logic [2:0] RVC_F3_BNEZ  = 3'b111;
  // C.SW in Q0 and C.SWSP in Q2
  localparam logic [2:0] RVC_F3_SW    = 3'b110;

  ////////////////////////////////////////////////////////////////////////////
  // Sequential PC steps
  localparam pc_t PC_STEP_RV32 = pc_t'(4);
  localparam pc_t PC_STEP_RVC  = pc_t'(2);

endpackage
